//--- alu_unit.sv
// single-cycle alu with a one-result hold slot for the cdb
`timescale 1ns/1ps

module alu_unit #(
    parameter int rob_depth = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         alu_issue,
    input  exec_pkg::op_t                issue_op,
    input  rename_pkg::data_t            issue_imm,
    input  rename_pkg::data_t            operand_a,
    input  rename_pkg::data_t            operand_b,
    input  rename_pkg::preg_t            issue_dest_tag,
    input  logic [$clog2(rob_depth)-1:0] issue_rob_idx,
    input  logic                         alu_grant,
    output logic                         alu_request,
    output logic                         alu_busy,
    output rename_pkg::preg_t            alu_tag,
    output logic [$clog2(rob_depth)-1:0] alu_rob_idx,
    output rename_pkg::data_t            alu_data
);
    import rename_pkg::*;
    import exec_pkg::*;

    data_t result;

    always_comb begin
        case (issue_op)
            op_add:  result = operand_a + operand_b;
            op_sub:  result = operand_a - operand_b;
            op_and:  result = operand_a & operand_b;
            op_xor:  result = operand_a ^ operand_b;
            op_li:   result = issue_imm;
            default: result = '0;
        endcase
    end

    // slot full and losing arbitration
    assign alu_busy = alu_request && !alu_grant;

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_request <= 1'b0;
        end else begin
            alu_request <= alu_issue || alu_busy;
        end
    end

    // no issue while busy, so the held result is never overwritten
    always_ff @(posedge clock) begin
        if (alu_issue) begin
            alu_tag     <= issue_dest_tag;
            alu_rob_idx <= issue_rob_idx;
            alu_data    <= result;
        end
    end

endmodule

//--- cdb_arbiter.sv
// fixed-priority cdb arbiter between multiplier and alu
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int rob_depth = 8
) (
    input  logic                         alu_request,
    input  rename_pkg::preg_t            alu_tag,
    input  logic [$clog2(rob_depth)-1:0] alu_rob_idx,
    input  rename_pkg::data_t            alu_data,
    input  logic                         mult_request,
    input  rename_pkg::preg_t            mult_tag,
    input  logic [$clog2(rob_depth)-1:0] mult_rob_idx,
    input  rename_pkg::data_t            mult_data,
    output logic                         alu_grant,
    output logic                         cdb_valid,
    output rename_pkg::preg_t            cdb_tag,
    output logic [$clog2(rob_depth)-1:0] cdb_rob_idx,
    output rename_pkg::data_t            cdb_data
);

    // multiplier cannot stall, so it always wins
    assign alu_grant = alu_request && !mult_request;
    assign cdb_valid = alu_request || mult_request;

    // broadcast mux
    assign cdb_tag     = mult_request ? mult_tag : alu_tag;
    assign cdb_rob_idx = mult_request ? mult_rob_idx : alu_rob_idx;
    assign cdb_data    = mult_request ? mult_data : alu_data;

endmodule

//--- exec_pkg.sv
// operation encoding, functional unit kinds and op to unit mapping
package exec_pkg;

    // li writes the immediate, both sources ignored
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul,
        op_li
    } op_t;

    typedef enum logic {
        fu_alu,
        fu_mult
    } fu_t;

    // only mul goes to the multiplier
    function automatic fu_t fu_of(op_t op);
        return (op == op_mul) ? fu_mult : fu_alu;
    endfunction

endpackage

//--- issue_queue.sv
// issue queue with cdb wakeup and oldest-ready selection
`timescale 1ns/1ps

module issue_queue #(
    parameter int iq_depth  = 4,
    parameter int rob_depth = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         dispatch_fire,
    input  exec_pkg::op_t                dispatch_op,
    input  rename_pkg::data_t            dispatch_imm,
    input  rename_pkg::preg_t            src1_tag,
    input  rename_pkg::preg_t            src2_tag,
    input  rename_pkg::preg_t            dest_tag,
    input  logic                         src1_ready,
    input  logic                         src2_ready,
    input  logic [$clog2(rob_depth)-1:0] rob_tail_idx,
    input  logic                         cdb_valid,
    input  rename_pkg::preg_t            cdb_tag,
    input  logic                         alu_busy,
    output logic                         iq_full,
    output rename_pkg::preg_t            read_tag_1,
    output rename_pkg::preg_t            read_tag_2,
    output logic                         alu_issue,
    output logic                         mult_issue,
    output exec_pkg::op_t                issue_op,
    output rename_pkg::data_t            issue_imm,
    output rename_pkg::preg_t            issue_dest_tag,
    output logic [$clog2(rob_depth)-1:0] issue_rob_idx
);
    import rename_pkg::*;
    import exec_pkg::*;

    // slot index, also wide enough for the age count
    localparam int slot_w = $clog2(iq_depth);
    localparam int idx_w  = $clog2(rob_depth);

    logic [iq_depth-1:0] valid;
    logic [iq_depth-1:0] rdy1;
    logic [iq_depth-1:0] rdy2;
    op_t e_op [iq_depth];
    data_t e_imm [iq_depth];
    preg_t e_src1 [iq_depth];
    preg_t e_src2 [iq_depth];
    preg_t e_dest [iq_depth];
    logic [idx_w-1:0] e_rob [iq_depth];
    // number of younger valid entries, so larger is older
    logic [slot_w-1:0] e_age [iq_depth];
    logic found;
    logic [slot_w-1:0] sel;
    logic [slot_w-1:0] free_slot;
    logic is_li;

    //////////////////////////////
    // select
    //////////////////////////////

    // oldest entry with both operands and a unit that can take it
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < iq_depth; i++) begin
            if (valid[i] && rdy1[i] && rdy2[i]
                    && !(alu_busy && (fu_of(e_op[i]) == fu_alu))
                    && (!found || (e_age[i] > e_age[sel]))) begin
                found = 1'b1;
                sel   = slot_w'(i);
            end
        end
    end

    // lowest empty slot
    always_comb begin
        free_slot = '0;
        for (int i = iq_depth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_slot = slot_w'(i);
            end
        end
    end

    assign iq_full    = &valid;
    assign alu_issue  = found && (fu_of(e_op[sel]) == fu_alu);
    assign mult_issue = found && (fu_of(e_op[sel]) == fu_mult);

    // operands read from the regfile in the issue cycle
    assign read_tag_1     = e_src1[sel];
    assign read_tag_2     = e_src2[sel];
    assign issue_op       = e_op[sel];
    assign issue_imm      = e_imm[sel];
    assign issue_dest_tag = e_dest[sel];
    assign issue_rob_idx  = e_rob[sel];

    // li needs no operands
    assign is_li = (dispatch_op == op_li);

    //////////////////////////////
    // entry state
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            rdy1  <= '0;
            rdy2  <= '0;
        end else begin
            // wakeup
            for (int i = 0; i < iq_depth; i++) begin
                if (cdb_valid && (e_src1[i] == cdb_tag)) begin
                    rdy1[i] <= 1'b1;
                end
                if (cdb_valid && (e_src2[i] == cdb_tag)) begin
                    rdy2[i] <= 1'b1;
                end
            end
            if (found) begin
                valid[sel] <= 1'b0;
            end
            if (dispatch_fire) begin
                valid[free_slot] <= 1'b1;
                rdy1[free_slot]  <= src1_ready || is_li;
                rdy2[free_slot]  <= src2_ready || is_li;
            end
        end
    end

    always_ff @(posedge clock) begin
        // age up on insert, down when a younger entry leaves
        for (int i = 0; i < iq_depth; i++) begin
            e_age[i] <= e_age[i] + slot_w'(dispatch_fire)
                        - slot_w'(found && (e_age[i] > e_age[sel]));
        end
        if (dispatch_fire) begin
            e_age[free_slot]  <= '0;
            e_op[free_slot]   <= dispatch_op;
            e_imm[free_slot]  <= dispatch_imm;
            e_src1[free_slot] <= src1_tag;
            e_src2[free_slot] <= src2_tag;
            e_dest[free_slot] <= dest_tag;
            e_rob[free_slot]  <= rob_tail_idx;
        end
    end

endmodule

//--- mult_unit.sv
// fixed-depth pipelined multiplier keeping the low word of the product
`timescale 1ns/1ps

module mult_unit #(
    parameter int mult_stages = 3,
    parameter int rob_depth   = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         mult_issue,
    input  rename_pkg::data_t            operand_a,
    input  rename_pkg::data_t            operand_b,
    input  rename_pkg::preg_t            issue_dest_tag,
    input  logic [$clog2(rob_depth)-1:0] issue_rob_idx,
    output logic                         mult_request,
    output rename_pkg::preg_t            mult_tag,
    output logic [$clog2(rob_depth)-1:0] mult_rob_idx,
    output rename_pkg::data_t            mult_data
);
    import rename_pkg::*;

    logic [mult_stages-1:0] stage_valid;
    preg_t stage_tag [mult_stages];
    logic [$clog2(rob_depth)-1:0] stage_rob [mult_stages];
    data_t stage_data [mult_stages];

    // valid bits shift every cycle, the cdb always takes the last stage
    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= mult_issue;
            for (int i = 1; i < mult_stages; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    // low 32 bits only
    always_ff @(posedge clock) begin
        stage_tag[0]  <= issue_dest_tag;
        stage_rob[0]  <= issue_rob_idx;
        stage_data[0] <= operand_a * operand_b;
        for (int i = 1; i < mult_stages; i++) begin
            stage_tag[i]  <= stage_tag[i-1];
            stage_rob[i]  <= stage_rob[i-1];
            stage_data[i] <= stage_data[i-1];
        end
    end

    assign mult_request = stage_valid[mult_stages-1];
    assign mult_tag     = stage_tag[mult_stages-1];
    assign mult_rob_idx = stage_rob[mult_stages-1];
    assign mult_data    = stage_data[mult_stages-1];

endmodule

//--- ooo_core.f
rename_pkg.sv
exec_pkg.sv
rename_unit.sv
reorder_buffer.sv
phys_regfile.sv
issue_queue.sv
alu_unit.sv
mult_unit.sv
cdb_arbiter.sv
ooo_core.sv
tb_ooo_core.sv

//--- ooo_core.sv
// out-of-order core top level with rename, rob, regfile, issue, units and cdb
`timescale 1ns/1ps

module ooo_core #(
    parameter int rob_depth   = 8,
    parameter int iq_depth    = 4,
    parameter int mult_stages = 3
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  exec_pkg::op_t         dispatch_op,
    input  rename_pkg::arch_reg_t dispatch_dest,
    input  rename_pkg::arch_reg_t dispatch_src1,
    input  rename_pkg::arch_reg_t dispatch_src2,
    input  rename_pkg::data_t     dispatch_imm,
    output logic                  dispatch_stall,
    output logic                  commit_valid,
    output logic                  commit_wr_en,
    output rename_pkg::arch_reg_t commit_arch_reg,
    output rename_pkg::data_t     commit_data
);
    import rename_pkg::*;
    import exec_pkg::*;

    localparam int idx_w = $clog2(rob_depth);

    //////////////////////////////
    // dispatch and rename
    //////////////////////////////

    logic dispatch_fire;
    logic free_list_empty;
    logic rob_full;
    logic iq_full;
    preg_t src1_tag;
    preg_t src2_tag;
    preg_t dest_tag;
    preg_t prev_dest_tag;
    logic src1_ready;
    logic src2_ready;
    logic free_valid;
    preg_t free_tag;
    logic [idx_w-1:0] rob_tail_idx;

    // issue and execute
    preg_t read_tag_1;
    preg_t read_tag_2;
    data_t read_data_1;
    data_t read_data_2;
    logic alu_issue;
    logic mult_issue;
    op_t issue_op;
    data_t issue_imm;
    preg_t issue_dest_tag;
    logic [idx_w-1:0] issue_rob_idx;
    logic alu_busy;
    logic alu_grant;
    logic alu_request;
    preg_t alu_tag;
    logic [idx_w-1:0] alu_rob_idx;
    data_t alu_data;
    logic mult_request;
    preg_t mult_tag;
    logic [idx_w-1:0] mult_rob_idx;
    data_t mult_data;

    // cdb
    logic cdb_valid;
    preg_t cdb_tag;
    logic [idx_w-1:0] cdb_rob_idx;
    data_t cdb_data;

    // a dest 0 needs no free preg
    assign dispatch_stall = (free_list_empty && (dispatch_dest != '0)) || rob_full || iq_full;
    assign dispatch_fire  = dispatch_valid && !dispatch_stall;

    rename_unit rename_unit_0 (
        .clock(clock),
        .reset(reset),
        .dispatch_fire(dispatch_fire),
        .dispatch_dest(dispatch_dest),
        .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2),
        .free_valid(free_valid),
        .free_tag(free_tag),
        .src1_tag(src1_tag),
        .src2_tag(src2_tag),
        .dest_tag(dest_tag),
        .prev_dest_tag(prev_dest_tag),
        .free_list_empty(free_list_empty)
    );

    reorder_buffer #(.rob_depth(rob_depth)) reorder_buffer_0 (
        .clock(clock),
        .reset(reset),
        .dispatch_fire(dispatch_fire),
        .dispatch_dest(dispatch_dest),
        .dest_tag(dest_tag),
        .prev_dest_tag(prev_dest_tag),
        .cdb_valid(cdb_valid),
        .cdb_rob_idx(cdb_rob_idx),
        .cdb_data(cdb_data),
        .rob_tail_idx(rob_tail_idx),
        .rob_full(rob_full),
        .free_valid(free_valid),
        .free_tag(free_tag),
        .commit_valid(commit_valid),
        .commit_wr_en(commit_wr_en),
        .commit_arch_reg(commit_arch_reg),
        .commit_data(commit_data)
    );

    phys_regfile phys_regfile_0 (
        .clock(clock),
        .reset(reset),
        .alloc_valid(dispatch_fire),
        .alloc_tag(dest_tag),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_data(cdb_data),
        .read_tag_1(read_tag_1),
        .read_tag_2(read_tag_2),
        .ready_tag_1(src1_tag),
        .ready_tag_2(src2_tag),
        .read_data_1(read_data_1),
        .read_data_2(read_data_2),
        .ready_1(src1_ready),
        .ready_2(src2_ready)
    );

    //////////////////////////////
    // issue, units, cdb
    //////////////////////////////

    issue_queue #(.iq_depth(iq_depth), .rob_depth(rob_depth)) issue_queue_0 (
        .clock(clock),
        .reset(reset),
        .dispatch_fire(dispatch_fire),
        .dispatch_op(dispatch_op),
        .dispatch_imm(dispatch_imm),
        .src1_tag(src1_tag),
        .src2_tag(src2_tag),
        .dest_tag(dest_tag),
        .src1_ready(src1_ready),
        .src2_ready(src2_ready),
        .rob_tail_idx(rob_tail_idx),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .alu_busy(alu_busy),
        .iq_full(iq_full),
        .read_tag_1(read_tag_1),
        .read_tag_2(read_tag_2),
        .alu_issue(alu_issue),
        .mult_issue(mult_issue),
        .issue_op(issue_op),
        .issue_imm(issue_imm),
        .issue_dest_tag(issue_dest_tag),
        .issue_rob_idx(issue_rob_idx)
    );

    alu_unit #(.rob_depth(rob_depth)) alu_unit_0 (
        .clock(clock),
        .reset(reset),
        .alu_issue(alu_issue),
        .issue_op(issue_op),
        .issue_imm(issue_imm),
        .operand_a(read_data_1),
        .operand_b(read_data_2),
        .issue_dest_tag(issue_dest_tag),
        .issue_rob_idx(issue_rob_idx),
        .alu_grant(alu_grant),
        .alu_request(alu_request),
        .alu_busy(alu_busy),
        .alu_tag(alu_tag),
        .alu_rob_idx(alu_rob_idx),
        .alu_data(alu_data)
    );

    mult_unit #(.mult_stages(mult_stages), .rob_depth(rob_depth)) mult_unit_0 (
        .clock(clock),
        .reset(reset),
        .mult_issue(mult_issue),
        .operand_a(read_data_1),
        .operand_b(read_data_2),
        .issue_dest_tag(issue_dest_tag),
        .issue_rob_idx(issue_rob_idx),
        .mult_request(mult_request),
        .mult_tag(mult_tag),
        .mult_rob_idx(mult_rob_idx),
        .mult_data(mult_data)
    );

    cdb_arbiter #(.rob_depth(rob_depth)) cdb_arbiter_0 (
        .alu_request(alu_request),
        .alu_tag(alu_tag),
        .alu_rob_idx(alu_rob_idx),
        .alu_data(alu_data),
        .mult_request(mult_request),
        .mult_tag(mult_tag),
        .mult_rob_idx(mult_rob_idx),
        .mult_data(mult_data),
        .alu_grant(alu_grant),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_rob_idx(cdb_rob_idx),
        .cdb_data(cdb_data)
    );

endmodule

//--- ooo_core_golden.mem
// per line: op, dest, src1, src2 as one hex digit each, then imm and expected commit data
// op 0 add, 1 sub, 2 and, 3 xor, 4 mul, 5 li; expected data is not checked for dest 0
51000000000500000005
52000000000200000002
53000000000300000003
5400000000f0000000f0
05120000000000000007
15530000000000000004
365400000000000000f4
266400000000000000f0
076500000000000000f4
182100000000fffffffd
497300000000000002dc
0a130000000000000008
3b230000000000000001
1c4100000000000000eb
00140000000000000000
0d020000000000000002
4f230000000000000006
4ff2000000000000000c
4ff20000000000000018
4ff30000000000000048
4ff20000000000000090
4ff300000000000001b0
41f30000000000000510
42f500000000000006c0
46ff000000000002d900
48f40000000000019500
4af30000000000000510
0b120000000000000bd0

//--- phys_regfile.sv
// physical register values and ready bits, two read ports, cdb write port
`timescale 1ns/1ps

module phys_regfile (
    input  logic              clock,
    input  logic              reset,
    input  logic              alloc_valid,
    input  rename_pkg::preg_t alloc_tag,
    input  logic              cdb_valid,
    input  rename_pkg::preg_t cdb_tag,
    input  rename_pkg::data_t cdb_data,
    input  rename_pkg::preg_t read_tag_1,
    input  rename_pkg::preg_t read_tag_2,
    input  rename_pkg::preg_t ready_tag_1,
    input  rename_pkg::preg_t ready_tag_2,
    output rename_pkg::data_t read_data_1,
    output rename_pkg::data_t read_data_2,
    output logic              ready_1,
    output logic              ready_2
);
    import rename_pkg::*;

    data_t values [num_phys_regs];
    logic [num_phys_regs-1:0] ready;

    // preg 0 is never written, stays zero
    assign read_data_1 = values[read_tag_1];
    assign read_data_2 = values[read_tag_2];

    // a broadcast in the dispatch cycle already counts as ready
    assign ready_1 = ready[ready_tag_1] || (cdb_valid && (cdb_tag == ready_tag_1));
    assign ready_2 = ready[ready_tag_2] || (cdb_valid && (cdb_tag == ready_tag_2));

    always_ff @(posedge clock) begin
        if (reset) begin
            // architectural state starts at zero
            for (int i = 0; i < num_phys_regs; i++) begin
                values[i] <= '0;
            end
            ready <= '1;
        end else begin
            // new dest waits for its producer
            if (alloc_valid && (alloc_tag != '0)) begin
                ready[alloc_tag] <= 1'b0;
            end
            if (cdb_valid && (cdb_tag != '0)) begin
                values[cdb_tag] <= cdb_data;
                ready[cdb_tag]  <= 1'b1;
            end
        end
    end

endmodule

//--- rename_pkg.sv
// data word and register index types for renaming and register storage
package rename_pkg;

    // data path width
    localparam int xlen = 32;
    typedef logic [xlen-1:0] data_t;

    //////////////////////////////
    // register spaces
    //////////////////////////////

    // arch reg 0 reads zero, never renamed
    localparam int num_arch_regs = 16;
    typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;

    // preg i holds arch reg i out of reset, 16..31 start free
    localparam int num_phys_regs = 32;
    typedef logic [$clog2(num_phys_regs)-1:0] preg_t;

endpackage

//--- rename_unit.sv
// map table and circular free list for renaming dispatched instructions
`timescale 1ns/1ps

module rename_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_fire,
    input  rename_pkg::arch_reg_t dispatch_dest,
    input  rename_pkg::arch_reg_t dispatch_src1,
    input  rename_pkg::arch_reg_t dispatch_src2,
    input  logic                  free_valid,
    input  rename_pkg::preg_t     free_tag,
    output rename_pkg::preg_t     src1_tag,
    output rename_pkg::preg_t     src2_tag,
    output rename_pkg::preg_t     dest_tag,
    output rename_pkg::preg_t     prev_dest_tag,
    output logic                  free_list_empty
);
    import rename_pkg::*;

    // never more free pregs than the non-architectural ones
    localparam int fl_depth = num_phys_regs - num_arch_regs;
    localparam int fl_w     = $clog2(fl_depth);

    preg_t map_table [num_arch_regs];
    preg_t free_list [fl_depth];
    // pointers carry one wrap bit
    logic [fl_w:0] head;
    logic [fl_w:0] tail;
    logic alloc;

    // lookups see the map as it was before this dispatch
    assign src1_tag      = map_table[dispatch_src1];
    assign src2_tag      = map_table[dispatch_src2];
    assign prev_dest_tag = map_table[dispatch_dest];

    // dest 0 keeps preg 0 and pops nothing
    assign dest_tag = (dispatch_dest != '0) ? free_list[head[fl_w-1:0]] : '0;
    assign alloc    = dispatch_fire && (dispatch_dest != '0);

    assign free_list_empty = (head == tail);

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map
            for (int i = 0; i < num_arch_regs; i++) begin
                map_table[i] <= preg_t'(i);
            end
            for (int i = 0; i < fl_depth; i++) begin
                free_list[i] <= preg_t'(num_arch_regs + i);
            end
            head <= '0;
            // list starts full, tail one lap ahead
            tail <= {1'b1, {fl_w{1'b0}}};
        end else begin
            if (alloc) begin
                map_table[dispatch_dest] <= dest_tag;
                head <= head + 1'b1;
            end
            // retired old mappings come back here
            if (free_valid) begin
                free_list[tail[fl_w-1:0]] <= free_tag;
                tail <= tail + 1'b1;
            end
        end
    end

endmodule

//--- reorder_buffer.sv
// reorder buffer with in-order allocation, cdb completion and registered commit
`timescale 1ns/1ps

module reorder_buffer #(
    parameter int rob_depth = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         dispatch_fire,
    input  rename_pkg::arch_reg_t        dispatch_dest,
    input  rename_pkg::preg_t            dest_tag,
    input  rename_pkg::preg_t            prev_dest_tag,
    input  logic                         cdb_valid,
    input  logic [$clog2(rob_depth)-1:0] cdb_rob_idx,
    input  rename_pkg::data_t            cdb_data,
    output logic [$clog2(rob_depth)-1:0] rob_tail_idx,
    output logic                         rob_full,
    output logic                         free_valid,
    output rename_pkg::preg_t            free_tag,
    output logic                         commit_valid,
    output logic                         commit_wr_en,
    output rename_pkg::arch_reg_t        commit_arch_reg,
    output rename_pkg::data_t            commit_data
);
    import rename_pkg::*;

    localparam int idx_w = $clog2(rob_depth);

    // entry payload
    arch_reg_t entry_dest [rob_depth];
    preg_t entry_prev [rob_depth];
    data_t entry_data [rob_depth];
    logic [rob_depth-1:0] entry_renamed;
    // completion flags
    logic [rob_depth-1:0] entry_done;
    logic [idx_w:0] head;
    logic [idx_w:0] tail;
    logic [idx_w-1:0] head_idx;
    logic retire;

    assign head_idx     = head[idx_w-1:0];
    assign rob_tail_idx = tail[idx_w-1:0];
    // same slot, opposite lap
    assign rob_full = (head[idx_w] != tail[idx_w]) && (head_idx == rob_tail_idx);
    // head leaves once its result is in
    assign retire = (head != tail) && entry_done[head_idx];

    //////////////////////////////
    // entry storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (dispatch_fire) begin
            entry_dest[rob_tail_idx]    <= dispatch_dest;
            entry_prev[rob_tail_idx]    <= prev_dest_tag;
            entry_renamed[rob_tail_idx] <= (dest_tag != '0);
        end
        if (cdb_valid) begin
            entry_data[cdb_rob_idx] <= cdb_data;
        end
    end

    //////////////////////////////
    // pointers and retire
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head         <= '0;
            tail         <= '0;
            entry_done   <= '0;
            commit_valid <= 1'b0;
            commit_wr_en <= 1'b0;
            free_valid   <= 1'b0;
        end else begin
            if (dispatch_fire) begin
                tail <= tail + 1'b1;
                entry_done[rob_tail_idx] <= 1'b0;
            end
            if (cdb_valid) begin
                entry_done[cdb_rob_idx] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            commit_valid <= retire;
            commit_wr_en <= retire && (entry_dest[head_idx] != '0);
            // old mapping of a renamed dest goes back to the free list
            free_valid   <= retire && entry_renamed[head_idx];
        end
    end

    // commit payload
    always_ff @(posedge clock) begin
        if (retire) begin
            commit_arch_reg <= entry_dest[head_idx];
            commit_data     <= entry_data[head_idx];
            free_tag        <= entry_prev[head_idx];
        end
    end

endmodule

//--- tb_ooo_core.sv
// clock, reset, golden stream dispatch driver and in-order commit checker for the core
`timescale 1ns/1ps

module tb_ooo_core;
    import rename_pkg::*;
    import exec_pkg::*;

    localparam int num_insts    = 28;
    // cycles a single wait may take before the run is stopped
    localparam int stall_limit  = 100;
    localparam int commit_limit = 200;

    logic clock;
    logic reset;
    logic dispatch_valid;
    op_t dispatch_op;
    arch_reg_t dispatch_dest;
    arch_reg_t dispatch_src1;
    arch_reg_t dispatch_src2;
    data_t dispatch_imm;
    logic dispatch_stall;
    logic commit_valid;
    logic commit_wr_en;
    arch_reg_t commit_arch_reg;
    data_t commit_data;

    // op, dest, src1, src2 nibbles then imm and expected data words
    logic [79:0] golden [num_insts];
    integer seed;
    int taken_count;
    logic stall_seen;

    ooo_core UUT (
        .clock(clock),
        .reset(reset),
        .dispatch_valid(dispatch_valid),
        .dispatch_op(dispatch_op),
        .dispatch_dest(dispatch_dest),
        .dispatch_src1(dispatch_src1),
        .dispatch_src2(dispatch_src2),
        .dispatch_imm(dispatch_imm),
        .dispatch_stall(dispatch_stall),
        .commit_valid(commit_valid),
        .commit_wr_en(commit_wr_en),
        .commit_arch_reg(commit_arch_reg),
        .commit_data(commit_data)
    );

    // 100 ns period
    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    //////////////////////////////
    // reporting
    //////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("error at %0t ns: %s is %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    //////////////////////////////
    // dispatch driver
    //////////////////////////////

    task automatic drive_stream();
        int gap;
        int waited;
        @(posedge clock);
        for (int i = 0; i < num_insts; i++) begin
            // random idle cycles between instructions
            gap = $unsigned($random(seed)) % 3;
            if (gap > 0) begin
                dispatch_valid <= 1'b0;
                repeat (gap) @(posedge clock);
            end
            dispatch_valid <= 1'b1;
            dispatch_op    <= op_t'(golden[i][78:76]);
            dispatch_dest  <= golden[i][75:72];
            dispatch_src1  <= golden[i][71:68];
            dispatch_src2  <= golden[i][67:64];
            dispatch_imm   <= golden[i][63:32];
            // same instruction held while stalled
            waited = 0;
            @(negedge clock);
            while (dispatch_stall) begin
                stall_seen = 1'b1;
                waited++;
                if (waited > stall_limit) begin
                    abort_run($sformatf("dispatch %0d stayed stalled for over %0d cycles",
                                        i, stall_limit));
                end
                @(negedge clock);
            end
            // stall low here, so the next edge takes it
            @(posedge clock);
            taken_count++;
        end
        dispatch_valid <= 1'b0;
    endtask

    //////////////////////////////
    // commit checker
    //////////////////////////////

    task automatic check_commits();
        int idle;
        arch_reg_t dest;
        for (int n = 0; n < num_insts; n++) begin
            idle = 0;
            @(negedge clock);
            while (!commit_valid) begin
                idle++;
                if (idle > commit_limit) begin
                    abort_run($sformatf("commit %0d did not arrive within %0d cycles",
                                        n, commit_limit));
                end
                @(negedge clock);
            end
            // commits never run ahead of accepted dispatches
            if (n >= taken_count) begin
                abort_run($sformatf("commit %0d appeared before its dispatch", n));
            end
            dest = golden[n][75:72];
            check_equal($sformatf("commit %0d arch reg", n), 32'(commit_arch_reg), 32'(dest));
            // dest 0 retires without a register write
            check_equal($sformatf("commit %0d wr_en", n), 32'(commit_wr_en), 32'(dest != '0));
            if (dest != '0) begin
                check_equal($sformatf("commit %0d data", n), commit_data, golden[n][31:0]);
            end
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        seed           = 32'h179b;
        taken_count    = 0;
        stall_seen     = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = op_add;
        dispatch_dest  = '0;
        dispatch_src1  = '0;
        dispatch_src2  = '0;
        dispatch_imm   = '0;
        $readmemh("ooo_core_golden.mem", golden);
        if (^golden[num_insts-1] === 1'bx) begin
            abort_run("the golden file is missing or shorter than the instruction count");
        end
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        // idle core after reset
        @(negedge clock);
        check_equal("dispatch_stall after reset", 32'(dispatch_stall), 32'd0);
        check_equal("commit_valid after reset", 32'(commit_valid), 32'd0);
        fork
            drive_stream();
            check_commits();
        join
        // the multiply burst has to back up dispatch at least once
        if (!stall_seen) begin
            abort_run("dispatch_stall never rose during the multiply burst");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule
